// ==== testbench/dac_scaler_patterns.txt ====
# W addr data strb bresp | R addr rdata rresp | C commit | S ch in0 in1 out0 out1
# All fields hex; out = low 16 bits of floor((x*scale + offset*2^18) / 2^16)
# Reset passthrough at unity gain
S 0 1234 5678 1234 5678
S 1 8000 7fff 8000 7fff
S 2 ffff 0001 ffff 0001
S 3 a5a5 5a5a a5a5 5a5a
S 0 0000 8001 0000 8001
# Register access and sign extension
R 00 00010000 0
R 04 00000000 0
W 00 00008000 f 0
W 04 00003000 f 0
R 00 00008000 0
R 04 fffff000 0
W 08 00030000 f 0
W 0c 00000100 f 0
R 08 ffff0000 0
R 0c 00000100 0
W 10 00021234 f 0
R 10 fffe1234 0
# Byte strobes on channel 2 scale
W 10 aa018000 6 0
R 10 00018034 0
W 10 00000000 1 0
R 10 00018000 0
W 14 00000000 f 0
W 18 00010000 f 0
W 1c 00001fff f 0
R 1c 00001fff 0
# Unmapped, misaligned and commit addresses
W 44 12345678 f 2
W 80 00000001 f 2
W 22 00000001 f 2
R 44 00000000 2
R 22 00000000 2
R 40 00000000 0
R fc 00000000 2
# Shadow writes alone leave the datapath at unity gain
S 0 1000 e000 1000 e000
S 1 0064 8000 0064 8000
S 2 7fff ffff 7fff ffff
S 3 7fff 8001 7fff 8001
C
# New settings on every channel
S 0 1000 e000 c800 b000
S 1 0064 8000 039c 8400
S 2 7fff ffff bffe fffe
S 3 7fff 8001 fffb fffd
# Arithmetic corners
S 0 7fff 8000 ffff 8000
S 1 0000 7fff 0400 8401
S 2 8000 0001 4000 0001
S 3 0000 0004 7ffc 8000
# Second commit with negative scale and negative offset
W 00 ffff8000 f 0
R 00 ffff8000 0
W 04 00000000 f 0
W 1c 00002000 f 0
R 1c ffffe000 0
C
S 0 0003 8000 fffe 4000
S 3 0000 7fff 8000 ffff
# Channel independence, back to back and gapped
S 1 0064 0000 039c 0400
S 2 ffff 8000 fffe 4000
S 0 0002 fffe ffff 0001
S 3 8001 0001 0001 8001
S 1 8000 7fff 8400 8401
S 2 0001 7fff 0001 bffe
S 1 ffff 0064 0401 039c

// ==== dac_scaler.f ====
design/dac_pkg.sv
design/scale_regs_axil.sv
design/dac_prescaler.sv
design/dac_scaler_top.sv
testbench/dac_scaler_checker.sv
testbench/tb_dac_scaler.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the DAC scaler testbench with Verilator and runs it.
# Pass or fail is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -f "$LOG"

verilator --binary --timing -Wno-fatal \
  -f dac_scaler.f \
  --top-module tb_dac_scaler \
  -Mdir obj_dir -o sim_dac_scaler \
  && ./obj_dir/sim_dac_scaler > "$LOG" 2>&1 \
  || { cat "$LOG" 2>/dev/null; echo "build or run error"; exit 1; }

cat "$LOG"

grep -q "^Simulation completed successfully$" "$LOG" \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }

// ==== testbench/tb_dac_scaler.sv ====
// Testbench top for the DAC scaler fed from testbench/dac_scaler_patterns.txt
// Run from the project root so the pattern file path resolves

module tb_dac_scaler
  import dac_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  logic        clk;
  logic        reset;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  sample_bus_t data_in;
  sample_bus_t data_out;

  logic [31:0] lfsr_state;
  bit          aborted; // Set on a timeout or a broken pattern file

  dac_scaler_top dac_scaler_top_inst (
    .clk      (clk),
    .reset    (reset),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .data_in  (data_in),
    .data_out (data_out)
  );

  dac_scaler_checker checker_inst (
    .clk      (clk),
    .reset    (reset),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .data_out (data_out)
  );

  // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] state);
    logic [31:0] shifted;
    shifted = state >> 1;
    if (state[0]) begin
      shifted = shifted ^ 32'h8020_0003;
    end
    return shifted;
  endfunction

  // Two LFSR bits give an idle gap of 0 to 3 cycles
  task automatic random_gap(output int gap);
    gap = 0;
    repeat (2) begin
      gap = (gap << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic bad_pattern(string cmd);
    $display("pattern file has a %s line with missing fields", cmd);
    aborted = 1'b1;
  endtask

  task automatic axil_write(axil_addr_t addr, axil_data_t data, axil_strb_t strb,
                            axil_resp_t resp);
    int waited;
    checker_inst.push_bresp(resp);
    axil_req.awvalid = 1'b1;
    axil_req.awaddr = addr;
    axil_req.wvalid = 1'b1;
    axil_req.wdata = data;
    axil_req.wstrb = strb;
    waited = 0;
    @(negedge clk);
    while (!(axil_rsp.awready && axil_rsp.wready) && waited < 100) begin
      @(negedge clk);
      waited++;
    end
    if (!(axil_rsp.awready && axil_rsp.wready)) begin
      $display("timeout: awready and wready never rose for write to %h", addr);
      aborted = 1'b1;
    end
    @(posedge clk);
    #1;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid = 1'b0;
    if (aborted) return;
    waited = 0;
    @(negedge clk);
    while (!axil_rsp.bvalid && waited < 100) begin
      @(negedge clk);
      waited++;
    end
    if (!axil_rsp.bvalid) begin
      $display("timeout: bvalid never rose for write to %h", addr);
      aborted = 1'b1;
    end
    @(posedge clk); // bready is held high so the response is taken here
    #1;
  endtask

  task automatic axil_read(axil_addr_t addr, axil_data_t data, axil_resp_t resp);
    int waited;
    checker_inst.push_read(data, resp);
    axil_req.arvalid = 1'b1;
    axil_req.araddr = addr;
    waited = 0;
    @(negedge clk);
    while (!axil_rsp.arready && waited < 100) begin
      @(negedge clk);
      waited++;
    end
    if (!axil_rsp.arready) begin
      $display("timeout: arready never rose for read from %h", addr);
      aborted = 1'b1;
    end
    @(posedge clk);
    #1;
    axil_req.arvalid = 1'b0;
    if (aborted) return;
    waited = 0;
    @(negedge clk);
    while (!axil_rsp.rvalid && waited < 100) begin
      @(negedge clk);
      waited++;
    end
    if (!axil_rsp.rvalid) begin
      $display("timeout: rvalid never rose for read from %h", addr);
      aborted = 1'b1;
    end
    @(posedge clk);
    #1;
  endtask

  // Waits until every expected beat and response has been seen
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (checker_inst.pending() != 0 && waited < 100) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (checker_inst.pending() != 0) begin
      $display("timeout: %0d expected items never showed up", checker_inst.pending());
      aborted = 1'b1;
    end
  endtask

  task automatic commit_settings();
    wait_drain(); // Nothing in flight across the switch
    if (aborted) return;
    axil_write(REG_COMMIT_ADDR, '0, '1, AXIL_RESP_OKAY);
    repeat (4) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic drive_beat(int ch, sample_t x0, sample_t x1, sample_t e0, sample_t e1);
    int gap;
    data_in.valid = '0;
    data_in.valid[ch] = 1'b1;
    data_in.data[ch][0] = x0;
    data_in.data[ch][1] = x1;
    checker_inst.push_beat(ch, checker_inst.cycle + PIPE_LATENCY, e0, e1);
    @(posedge clk);
    #1;
    data_in.valid = '0;
    random_gap(gap);
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    int          fd;
    int          n;
    string       cmd;
    string       line;
    logic [31:0] f0;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [31:0] f4;
    reset = 1'b1;
    axil_req = '0;
    axil_req.bready = 1'b1;
    axil_req.rready = 1'b1;
    data_in = '0;
    lfsr_state = 32'hd1ef62ed;
    aborted = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    fd = $fopen("testbench/dac_scaler_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file");
      aborted = 1'b1;
    end else begin
      while (!aborted && $fscanf(fd, "%s", cmd) == 1) begin
        case (cmd)
          "#": void'($fgets(line, fd)); // Comment line
          "W": begin
            n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
            if (n == 4) axil_write(f0[7:0], f1, f2[3:0], f3[1:0]);
            else bad_pattern(cmd);
          end
          "R": begin
            n = $fscanf(fd, "%h %h %h", f0, f1, f2);
            if (n == 3) axil_read(f0[7:0], f1, f2[1:0]);
            else bad_pattern(cmd);
          end
          "C": commit_settings();
          "S": begin
            n = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
            if (n == 5) drive_beat(int'(f0), f1[15:0], f2[15:0], f3[15:0], f4[15:0]);
            else bad_pattern(cmd);
          end
          default: begin
            $display("unknown pattern command %s", cmd);
            aborted = 1'b1;
          end
        endcase
      end
      $fclose(fd);
    end
    if (!aborted) wait_drain();
    checker_inst.report();
    if (aborted || checker_inst.fail_count != 0) begin
      $display("Simulation failed");
    end else begin
      $display("Simulation completed successfully");
    end
    $finish;
  end

endmodule

// ==== testbench/dac_scaler_checker.sv ====
// Compares DUT outputs with expected values queued by the testbench top
// A sample beat must show up exactly on its due cycle

module dac_scaler_checker
  import dac_pkg::*;
(
  input logic        clk,
  input logic        reset,
  input axil_req_t   axil_req,
  input axil_rsp_t   axil_rsp,
  input sample_bus_t data_out
);

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [31:0] due; // Cycle on which the beat must appear
    sample_t     s0;
    sample_t     s1;
  } beat_t;

  beat_t       beat_q [CHANNELS][$];
  axil_resp_t  bresp_q [$];
  axil_data_t  rdata_q [$];
  axil_resp_t  rresp_q [$];
  int unsigned cycle = 0; // Edges seen so far
  int          pass_count = 0;
  int          fail_count = 0;

  task automatic push_beat(int ch, logic [31:0] due, sample_t s0, sample_t s1);
    beat_q[ch].push_back('{due: due, s0: s0, s1: s1});
  endtask

  task automatic push_bresp(axil_resp_t resp);
    bresp_q.push_back(resp);
  endtask

  task automatic push_read(axil_data_t data, axil_resp_t resp);
    rdata_q.push_back(data);
    rresp_q.push_back(resp);
  endtask

  function automatic int pending();
    int total;
    total = bresp_q.size() + rdata_q.size();
    for (int c = 0; c < CHANNELS; c++) begin
      total += beat_q[c].size();
    end
    return total;
  endfunction

  task automatic check_field(string name, logic [31:0] expected, logic [31:0] actual,
                             inout bit ok);
    if (expected !== actual) begin
      $display("error t=%0t %s expected %h actual %h", $time, name, expected, actual);
      ok = 1'b0;
    end
  endtask

  task automatic tally(bit ok, string what);
    $display("%s %s", ok ? "pass" : "fail", what);
    if (ok) pass_count++;
    else fail_count++;
  endtask

  task automatic check_axil();
    bit ok;
    if (axil_rsp.bvalid && axil_req.bready) begin
      if (bresp_q.size() == 0) begin
        tally(1'b0, "write response arrived with no write outstanding");
      end else begin
        ok = 1'b1;
        check_field("bresp", 32'(bresp_q.pop_front()), 32'(axil_rsp.bresp), ok);
        tally(ok, $sformatf("write response at cycle %0d", cycle));
      end
    end
    if (axil_rsp.rvalid && axil_req.rready) begin
      if (rdata_q.size() == 0) begin
        tally(1'b0, "read response arrived with no read outstanding");
      end else begin
        ok = 1'b1;
        check_field("rdata", rdata_q.pop_front(), axil_rsp.rdata, ok);
        check_field("rresp", 32'(rresp_q.pop_front()), 32'(axil_rsp.rresp), ok);
        tally(ok, $sformatf("read response at cycle %0d", cycle));
      end
    end
  endtask

  task automatic check_samples();
    beat_t b;
    bit    ok;
    for (int c = 0; c < CHANNELS; c++) begin
      if (data_out.valid[c]) begin
        if (beat_q[c].size() == 0) begin
          $display("error t=%0t data_out.valid[%0d] expected 0 actual 1", $time, c);
          fail_count++;
        end else begin
          b = beat_q[c].pop_front();
          ok = 1'b1;
          check_field($sformatf("arrival cycle ch%0d", c), b.due, cycle, ok);
          check_field($sformatf("data_out.data[%0d][0]", c), {16'h0, b.s0},
                      {16'h0, data_out.data[c][0]}, ok);
          check_field($sformatf("data_out.data[%0d][1]", c), {16'h0, b.s1},
                      {16'h0, data_out.data[c][1]}, ok);
          tally(ok, $sformatf("sample beat ch%0d at cycle %0d", c, cycle));
        end
      end else if (beat_q[c].size() != 0 && beat_q[c][0].due <= cycle) begin
        b = beat_q[c].pop_front();
        tally(1'b0, $sformatf("beat on ch%0d due at cycle %0d never arrived", c, b.due));
      end
    end
  endtask

  // Outputs are read before this edge's register updates
  always @(posedge clk) begin
    if (!reset) begin
      check_axil();
      check_samples();
    end
    cycle = cycle + 1;
  end

  task automatic report();
    $display("checks: %0d passed, %0d failed", pass_count, fail_count);
  endtask

endmodule

// ==== design/dac_scaler_top.sv ====
// DAC scaler with AXI4-Lite control and a valid-only sample stream
// Writes to the scale and offset registers take effect only after a commit

module dac_scaler_top
  import dac_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  axil_req_t   axil_req,
  output axil_rsp_t   axil_rsp,
  input  sample_bus_t data_in,
  output sample_bus_t data_out
);

  channel_cfg_t cfg; // Shadow settings for every channel
  logic         cfg_load; // One cycle after a commit write

  // Register file on the AXI4-Lite bus
  scale_regs_axil scale_regs_inst (
    .clk      (clk),
    .reset    (reset),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .cfg      (cfg),
    .cfg_load (cfg_load)
  );

  // Sample datapath, five cycles from data_in to data_out
  dac_prescaler prescaler_inst (
    .clk      (clk),
    .reset    (reset),
    .data_in  (data_in),
    .cfg      (cfg),
    .cfg_load (cfg_load),
    .data_out (data_out)
  );

endmodule

// ==== design/dac_prescaler.sv ====
// Five-stage scale and offset of every sample, no back-pressure
// Settings apply to beats entering two or more cycles after cfg_load

module dac_prescaler
  import dac_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  sample_bus_t  data_in,
  input  channel_cfg_t cfg,
  input  logic         cfg_load,
  output sample_bus_t  data_out
);

  channel_cfg_t active; // Settings used by the multipliers

  sample_t  data_in_reg [CHANNELS][PARALLEL_SAMPLES]; // 0Q16
  product_t product [CHANNELS][PARALLEL_SAMPLES]; // 2Q32
  product_t offset_shifted [CHANNELS]; // 2Q32
  sum_t     sum [CHANNELS][PARALLEL_SAMPLES]; // 3Q32
  sample_t  sum_d [CHANNELS][PARALLEL_SAMPLES]; // 0Q16

  sample_t [CHANNELS-1:0][PARALLEL_SAMPLES-1:0] out_data;
  logic [CHANNELS-1:0][PIPE_LATENCY-1:0] valid_d;
  logic [CHANNELS-1:0] out_valid;

  // Offset moved to bit 18 so it lines up with the product's binary point
  always_comb begin
    for (int c = 0; c < CHANNELS; c++) begin
      offset_shifted[c] = {
        {SCALE_INT_BITS{active[c].offset[OFFSET_WIDTH-1]}},
        active[c].offset,
        {(SAMPLE_WIDTH+SCALE_FRAC_BITS-OFFSET_WIDTH){1'b0}}
      };
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_d <= '0;
      for (int c = 0; c < CHANNELS; c++) begin
        active[c] <= CFG_RESET; // Unity gain, zero offset
      end
    end else begin
      if (cfg_load) begin
        active <= cfg; // All channels switch together
      end
      for (int c = 0; c < CHANNELS; c++) begin
        valid_d[c] <= {valid_d[c][PIPE_LATENCY-2:0], data_in.valid[c]};
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int c = 0; c < CHANNELS; c++) begin
      for (int s = 0; s < PARALLEL_SAMPLES; s++) begin
        data_in_reg[c][s] <= data_in.data[c][s]; // Stage 1
        product[c][s] <= data_in_reg[c][s] * active[c].scale; // Stage 2
        sum[c][s] <= product[c][s] + offset_shifted[c]; // Stage 3
        sum_d[c][s] <= sum[c][s][SAMPLE_WIDTH+SCALE_FRAC_BITS-1 -: SAMPLE_WIDTH]; // Wraps
        out_data[c][s] <= sum_d[c][s]; // Stage 5
      end
    end
  end

  always_comb begin
    for (int c = 0; c < CHANNELS; c++) begin
      out_valid[c] = valid_d[c][PIPE_LATENCY-1];
    end
  end

  assign data_out = '{valid: out_valid, data: out_data};

endmodule

// ==== design/scale_regs_axil.sv ====
// AXI4-Lite shadow registers for per-channel scale and offset
// Address and data must arrive together; at most 8 channels fit below commit

module scale_regs_axil
  import dac_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  axil_req_t    axil_req,
  output axil_rsp_t    axil_rsp,
  output channel_cfg_t cfg,
  output logic         cfg_load
);

  typedef struct packed {
    logic                      reg_hit; // Scale or offset register
    logic                      commit;
    logic                      is_offset;
    logic [CHAN_IDX_WIDTH-1:0] chan;
  } reg_sel_t;

  channel_cfg_t shadow;
  reg_sel_t     aw_sel;
  reg_sel_t     ar_sel;
  logic         aw_accept;
  logic         ar_accept;
  axil_data_t   wr_current;
  axil_data_t   wr_merged;
  axil_data_t   rd_value;

  logic         bvalid;
  axil_resp_t   bresp;
  logic         rvalid;
  axil_data_t   rdata;
  axil_resp_t   rresp;

  function automatic reg_sel_t decode(axil_addr_t addr);
    reg_sel_t sel;
    sel.reg_hit = (addr < axil_addr_t'(8 * CHANNELS)) && (addr[1:0] == 2'b00);
    sel.commit = (addr == REG_COMMIT_ADDR);
    sel.is_offset = addr[2]; // Offset sits 4 bytes above its scale
    sel.chan = addr[3 +: CHAN_IDX_WIDTH];
    return sel;
  endfunction

  // Shadow value sign-extended to the bus width
  function automatic axil_data_t reg_value(channel_cfg_t regs, reg_sel_t sel);
    axil_data_t value;
    offset_t    off;
    scale_t     scl;
    value = '0;
    off = regs[sel.chan].offset;
    scl = regs[sel.chan].scale;
    if (sel.reg_hit) begin
      if (sel.is_offset) begin
        value = {{(AXIL_DATA_WIDTH-OFFSET_WIDTH){off[OFFSET_WIDTH-1]}}, off};
      end else begin
        value = {{(AXIL_DATA_WIDTH-SCALE_WIDTH){scl[SCALE_WIDTH-1]}}, scl};
      end
    end
    return value;
  endfunction

  function automatic axil_data_t merge_bytes(axil_data_t old_val, axil_data_t new_val,
                                             axil_strb_t strb);
    axil_data_t result;
    result = old_val;
    for (int b = 0; b < AXIL_STRB_WIDTH; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return result;
  endfunction

  assign aw_sel = decode(axil_req.awaddr);
  assign ar_sel = decode(axil_req.araddr);

  assign aw_accept = axil_req.awvalid && axil_req.wvalid && !bvalid; // One write in flight
  assign ar_accept = axil_req.arvalid && !rvalid;

  assign wr_current = reg_value(shadow, aw_sel);
  assign wr_merged = merge_bytes(wr_current, axil_req.wdata, axil_req.wstrb);
  assign rd_value = reg_value(shadow, ar_sel);

  always_ff @(posedge clk) begin
    if (reset) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
      cfg_load <= 1'b0;
      for (int c = 0; c < CHANNELS; c++) begin
        shadow[c] <= CFG_RESET;
      end
    end else begin
      cfg_load <= aw_accept && aw_sel.commit; // Rises with bvalid

      if (aw_accept) begin
        bvalid <= 1'b1;
      end else if (axil_req.bready) begin
        bvalid <= 1'b0;
      end

      if (ar_accept) begin
        rvalid <= 1'b1;
      end else if (axil_req.rready) begin
        rvalid <= 1'b0;
      end

      if (aw_accept && aw_sel.reg_hit) begin
        if (aw_sel.is_offset) begin
          shadow[aw_sel.chan].offset <= wr_merged[OFFSET_WIDTH-1:0];
        end else begin
          shadow[aw_sel.chan].scale <= wr_merged[SCALE_WIDTH-1:0];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_accept) begin
      bresp <= (aw_sel.reg_hit || aw_sel.commit) ? AXIL_RESP_OKAY : AXIL_RESP_SLVERR;
    end
    if (ar_accept) begin
      rdata <= rd_value; // Commit and unmapped read as zero
      rresp <= (ar_sel.reg_hit || ar_sel.commit) ? AXIL_RESP_OKAY : AXIL_RESP_SLVERR;
    end
  end

  always_comb begin
    axil_rsp.awready = aw_accept;
    axil_rsp.wready = aw_accept;
    axil_rsp.bvalid = bvalid;
    axil_rsp.bresp = bresp;
    axil_rsp.arready = ar_accept;
    axil_rsp.rvalid = rvalid;
    axil_rsp.rdata = rdata;
    axil_rsp.rresp = rresp;
  end

  assign cfg = shadow; // Sampled by the datapath only on cfg_load

endmodule

// ==== design/dac_pkg.sv ====
// Widths, fixed-point types, bus structs and register map of the DAC scaler
// Scaled results wrap on overflow and are never saturated

package dac_pkg;

  localparam int CHANNELS = 4;
  localparam int PARALLEL_SAMPLES = 2; // Samples per channel per beat
  localparam int SAMPLE_WIDTH = 16;
  localparam int SCALE_WIDTH = 18;
  localparam int SCALE_INT_BITS = 2;
  localparam int SCALE_FRAC_BITS = 16;
  localparam int OFFSET_WIDTH = 14;
  localparam int PIPE_LATENCY = 5; // data_in to data_out in cycles
  localparam int AXIL_ADDR_WIDTH = 8;
  localparam int AXIL_DATA_WIDTH = 32;
  localparam int AXIL_STRB_WIDTH = AXIL_DATA_WIDTH / 8;
  localparam int CHAN_IDX_WIDTH = $clog2(CHANNELS);
  localparam int PRODUCT_WIDTH = SAMPLE_WIDTH + SCALE_WIDTH;

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t; // 0Q16
  typedef logic signed [SCALE_WIDTH-1:0] scale_t; // 2Q16
  typedef logic signed [OFFSET_WIDTH-1:0] offset_t; // 0Q14
  typedef logic signed [PRODUCT_WIDTH-1:0] product_t; // 2Q32
  typedef logic signed [PRODUCT_WIDTH:0] sum_t; // 3Q32
  typedef logic [AXIL_ADDR_WIDTH-1:0] axil_addr_t;
  typedef logic [AXIL_DATA_WIDTH-1:0] axil_data_t;
  typedef logic [AXIL_STRB_WIDTH-1:0] axil_strb_t;
  typedef logic [1:0] axil_resp_t;

  localparam scale_t SCALE_RESET = scale_t'(1 << SCALE_FRAC_BITS); // 1.0
  localparam axil_addr_t REG_COMMIT_ADDR = 8'h40; // Scale at 8c, offset at 8c+4
  localparam axil_resp_t AXIL_RESP_OKAY = 2'b00;
  localparam axil_resp_t AXIL_RESP_SLVERR = 2'b10;

  typedef struct packed {
    scale_t  scale;
    offset_t offset;
  } scale_offset_t;

  typedef scale_offset_t [CHANNELS-1:0] channel_cfg_t;

  localparam scale_offset_t CFG_RESET = '{scale: SCALE_RESET, offset: '0};

  typedef struct packed {
    logic [CHANNELS-1:0]                             valid;
    sample_t [CHANNELS-1:0][PARALLEL_SAMPLES-1:0] data;
  } sample_bus_t;

  typedef struct packed {
    logic       awvalid;
    axil_addr_t awaddr;
    logic       wvalid;
    axil_data_t wdata;
    axil_strb_t wstrb;
    logic       bready;
    logic       arvalid;
    axil_addr_t araddr;
    logic       rready;
  } axil_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    axil_resp_t bresp;
    logic       arready;
    logic       rvalid;
    axil_data_t rdata;
    axil_resp_t rresp;
  } axil_rsp_t;

endpackage
